/* run.sh */
#!/bin/sh
# Build and run the switch testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

# Compile with timing and assertions enabled
verilator --binary --timing --assert -Wno-fatal \
    -f sources.f --top-module tb -o tb_sim > "$build_log" 2>&1
if [ $? -ne 0 ]; then
    cat "$build_log"
    echo "Verilator build failed"
    exit 1
fi

# Run the simulation
./obj_dir/tb_sim > "$sim_log" 2>&1
sim_status=$?
cat "$sim_log"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

# Result comes from the log
if grep -q "CHECKS FAILED" "$sim_log"; then
    exit 1
fi

exit 0

/* source/axis_pkg.sv */
package axis_pkg;

    import smartnic_pkg::*;

    // ==============================
    // Stream sizing
    // ==============================

    // Payload width per beat
    localparam int data_wid = 64;

    typedef logic [data_wid-1:0] axis_data_t;

    // ==============================
    // Beat types
    // ==============================

    // Ingress beat and FIFO entry
    typedef struct packed {
        axis_data_t tdata;
        logic       tlast;
        port_t      tdest;
    } axis_igr_beat_t;

    // Egress beat whose tid names the source port
    typedef struct packed {
        axis_data_t tdata;
        logic       tlast;
        egr_tid_t   tid;
    } axis_egr_beat_t;

endpackage : axis_pkg

/* source/smartnic_egr_arb.sv */
`timescale 1ns/1ns

module smartnic_egr_arb
    import axis_pkg::*;
    import smartnic_pkg::*;
(
    input  logic           clk,
    input  logic           rst_n,

    // Bit i set when FIFO i holds a head bound here
    input  port_mask_t     req,
    input  axis_igr_beat_t head_beat [num_ports],
    output port_mask_t     pop,

    // Egress stream
    output logic           egr_tvalid,
    input  logic           egr_tready,
    output axis_egr_beat_t egr_beat
);

    // ==============================
    // Grant state
    // ==============================

    // Zero while idle, one-hot while a packet is locked
    port_mask_t grant;

    // Current or most recent winner
    port_t win_idx;

    // Next pick
    port_t nxt_idx;
    logic  nxt_found;

    logic xfer;

    // Round robin search starting just past the last winner
    // Last candidate is the previous winner itself
    always_comb begin
        nxt_idx   = win_idx;
        nxt_found = 1'b0;
        for (int k = 1; k <= num_ports; k++) begin
            if (!nxt_found && req[port_t'(win_idx + port_t'(k))]) begin
                nxt_idx   = port_t'(win_idx + port_t'(k));
                nxt_found = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            grant   <= '0;
            // Port 0 gets the first turn
            win_idx <= port_t'(num_ports - 1);
        end else if (grant == '0) begin
            // Idle so latch a new winner
            if (nxt_found) begin
                grant   <= port_mask_t'(1) << nxt_idx;
                win_idx <= nxt_idx;
            end
        end else if (xfer && egr_beat.tlast) begin
            // Release after the last beat
            grant <= '0;
        end
    end

    // ==============================
    // Egress mux
    // ==============================

    // Granted head present and still aimed at this port
    assign egr_tvalid = |(grant & req);
    assign xfer       = egr_tvalid && egr_tready;

    assign egr_beat.tdata = head_beat[win_idx].tdata;
    assign egr_beat.tlast = head_beat[win_idx].tlast;
    assign egr_beat.tid   = egr_tid_t'(win_idx);

    // Drain only the granted FIFO
    assign pop = xfer ? grant : '0;

    // ==============================
    // Checks
    // ==============================

    grant_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(grant))
        else $error("egr_arb: grant not one-hot");

    // Source tag held for the whole packet
    tid_locked: assert property (@(posedge clk) disable iff (!rst_n)
        (xfer && !egr_beat.tlast) |=> $stable(egr_beat.tid))
        else $error("egr_arb: tid changed inside packet");

    // Pops reach only the granted FIFO while its head is bound here
    pop_granted: assert property (@(posedge clk) disable iff (!rst_n)
        (pop & ~(grant & req)) == '0)
        else $error("egr_arb: pop without grant");

endmodule : smartnic_egr_arb

/* source/smartnic_igr_fifo.sv */
`timescale 1ns/1ns

module smartnic_igr_fifo
    import axis_pkg::*;
    import smartnic_pkg::*;
(
    input  logic           clk,
    input  logic           rst_n,

    // Ingress stream
    input  logic           in_tvalid,
    output logic           in_tready,
    input  axis_igr_beat_t in_beat,

    // Head toward the arbiters
    output logic           head_valid,
    output axis_igr_beat_t head_beat,
    output port_mask_t     head_req,
    input  logic           pop
);

    // ==============================
    // Storage and pointers
    // ==============================

    axis_igr_beat_t mem [fifo_depth];

    fifo_ptr_t  wr_ptr;
    fifo_ptr_t  rd_ptr;
    fifo_ptr_t  mem_count;
    fifo_addr_t wr_addr;
    fifo_addr_t rd_addr;

    logic mem_empty;
    logic mem_full;
    logic push;
    logic head_ld;
    logic bypass;
    logic mem_wr;
    logic mem_rd;

    assign wr_addr   = wr_ptr[fifo_addr_wid-1:0];
    assign rd_addr   = rd_ptr[fifo_addr_wid-1:0];
    assign mem_count = wr_ptr - rd_ptr;

    // Wrap bit tells full from empty at equal addresses
    assign mem_empty = (wr_ptr == rd_ptr);
    assign mem_full  = (wr_addr == rd_addr) && (wr_ptr[fifo_addr_wid] != rd_ptr[fifo_addr_wid]);

    assign in_tready = !mem_full;
    assign push      = in_tvalid && in_tready;

    // Head register takes a new beat when empty or leaving
    assign head_ld = !head_valid || pop;

    // Empty buffer lets a pushed beat go straight to the head
    assign bypass = head_ld && mem_empty && push;
    assign mem_wr = push && !bypass;
    assign mem_rd = head_ld && !mem_empty;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            head_valid <= 1'b0;
        end else begin
            if (mem_wr) wr_ptr <= wr_ptr + 1'b1;
            if (mem_rd) rd_ptr <= rd_ptr + 1'b1;
            if (head_ld) head_valid <= mem_rd || bypass;
        end
    end

    // Payload path
    always_ff @(posedge clk) begin
        if (mem_wr) mem[wr_addr] <= in_beat;
        if (mem_rd) begin
            head_beat <= mem[rd_addr];
        end else if (bypass) begin
            head_beat <= in_beat;
        end
    end

    // One-hot destination of the current head
    assign head_req = port_mask_t'(1) << head_beat.tdest;

    // ==============================
    // Checks
    // ==============================

    // Arbiters only pop a present head
    pop_when_empty: assert property (@(posedge clk) disable iff (!rst_n) pop |-> head_valid)
        else $error("igr_fifo: pop with empty head");

    // Pointer distance never passes the buffer size
    count_bound: assert property (@(posedge clk) disable iff (!rst_n)
        mem_count <= fifo_ptr_t'(fifo_depth))
        else $error("igr_fifo: push into full buffer");

endmodule : smartnic_igr_fifo

/* source/smartnic_pkg.sv */
package smartnic_pkg;

    // ==============================
    // Port numbering
    // ==============================

    // Four switch ports on both sides
    // 0 and 1 face the MACs
    // 2 and 3 face the host (h2c on ingress, c2h on egress)
    localparam int num_ports = 4;

    // Port index
    typedef logic [$clog2(num_ports)-1:0] port_t;

    // One bit per port for requests, grants and pops
    typedef logic [num_ports-1:0] port_mask_t;

    // ==============================
    // Ingress buffering
    // ==============================

    // Beats held per ingress stream
    localparam int fifo_depth    = 16;
    localparam int fifo_addr_wid = $clog2(fifo_depth);

    // Buffer address
    typedef logic [fifo_addr_wid-1:0] fifo_addr_t;

    // Address plus wrap bit
    typedef logic [fifo_addr_wid:0] fifo_ptr_t;

    // ==============================
    // Egress metadata
    // ==============================

    // Stream id on egress carries the source port
    typedef port_t egr_tid_t;

endpackage : smartnic_pkg

/* source/smartnic_switch.sv */
`timescale 1ns/1ns

module smartnic_switch
    import axis_pkg::*;
    import smartnic_pkg::*;
(
    input  logic           clk,
    input  logic           rst_n,

    // Ingress from the MACs on 0-1 and from the host on 2-3
    input  logic           igr_tvalid [num_ports],
    output logic           igr_tready [num_ports],
    input  axis_igr_beat_t igr_beat   [num_ports],

    // Egress to the MACs on 0-1 and to the host on 2-3
    output logic           egr_tvalid [num_ports],
    input  logic           egr_tready [num_ports],
    output axis_egr_beat_t egr_beat   [num_ports]
);

    // ==============================
    // FIFO heads
    // ==============================

    logic           head_valid [num_ports];
    axis_igr_beat_t head_beat  [num_ports];
    port_mask_t     head_req   [num_ports];
    logic           fifo_pop   [num_ports];

    // Indexed by egress port with one bit per FIFO
    port_mask_t arb_req [num_ports];
    port_mask_t arb_pop [num_ports];

    // Indexed by FIFO with one bit per egress port
    port_mask_t fifo_pop_mask [num_ports];

    // Swap request and pop masks between FIFO and arbiter views
    always_comb begin
        for (int i = 0; i < num_ports; i++) begin
            for (int j = 0; j < num_ports; j++) begin
                arb_req[j][i]       = head_valid[i] && head_req[i][j];
                fifo_pop_mask[i][j] = arb_pop[j][i];
            end
        end
    end

    // ==============================
    // Ingress buffers
    // ==============================

    for (genvar i = 0; i < num_ports; i++) begin : g_igr
        assign fifo_pop[i] = |fifo_pop_mask[i];

        smartnic_igr_fifo igr_fifo_inst (
            .clk        (clk),
            .rst_n      (rst_n),
            .in_tvalid  (igr_tvalid[i]),
            .in_tready  (igr_tready[i]),
            .in_beat    (igr_beat[i]),
            .head_valid (head_valid[i]),
            .head_beat  (head_beat[i]),
            .head_req   (head_req[i]),
            .pop        (fifo_pop[i])
        );

        // A head leaves through one egress port at a time
        pop_single: assert property (@(posedge clk) disable iff (!rst_n)
            $onehot0(fifo_pop_mask[i]))
            else $error("switch: FIFO %0d popped by two arbiters", i);
    end

    // Per egress arbitration
    for (genvar j = 0; j < num_ports; j++) begin : g_egr
        smartnic_egr_arb egr_arb_inst (
            .clk        (clk),
            .rst_n      (rst_n),
            .req        (arb_req[j]),
            .head_beat  (head_beat),
            .pop        (arb_pop[j]),
            .egr_tvalid (egr_tvalid[j]),
            .egr_tready (egr_tready[j]),
            .egr_beat   (egr_beat[j])
        );
    end

endmodule : smartnic_switch

/* sources.f */
source/smartnic_pkg.sv
source/axis_pkg.sv
source/smartnic_igr_fifo.sv
source/smartnic_egr_arb.sv
source/smartnic_switch.sv
tb/tb.sv

/* tb/tb.sv */
`timescale 1ns/1ns

module tb
    import axis_pkg::*;
    import smartnic_pkg::*;
();

    localparam int clk_period    = 40;
    localparam int pkts_per_port = 12;
    localparam int max_beats     = 8;
    // Worst case 8 cycles per beat plus slack for reset and drain
    localparam int run_limit_ns  =
        (num_ports * pkts_per_port * max_beats * 8 + 200) * clk_period;

    logic           clk;
    logic           rst_n;
    logic           igr_tvalid [num_ports];
    logic           igr_tready [num_ports];
    axis_igr_beat_t igr_beat   [num_ports];
    logic           egr_tvalid [num_ports];
    logic           egr_tready [num_ports];
    axis_egr_beat_t egr_beat   [num_ports];

    logic [15:0] lfsr;
    int          errors;

    // Ingress generator state per source
    int          pkts_left  [num_ports];
    int          beats_left [num_ports];
    int          gap_left   [num_ports];
    port_t       cur_dest   [num_ports];
    logic        will_xfer  [num_ports];

    // Sequence counters per source and destination
    logic [15:0] tx_cnt [num_ports][num_ports];
    logic [15:0] rx_cnt [num_ports][num_ports];

    // Expected tlast per source, destination and sequence number
    logic        sent_last [num_ports][num_ports][256];

    // Egress tracking per port
    logic           egr_xfer  [num_ports];
    logic           pkt_open  [num_ports];
    port_t          pkt_tid   [num_ports];
    logic           stall_q   [num_ports];
    axis_egr_beat_t held_beat [num_ports];

    smartnic_switch smartnic_switch_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .igr_tvalid (igr_tvalid),
        .igr_tready (igr_tready),
        .igr_beat   (igr_beat),
        .egr_tvalid (egr_tvalid),
        .egr_tready (egr_tready),
        .egr_beat   (egr_beat)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // ==============================
    // Random source
    // ==============================

    // 16 bit Galois LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return (s >> 1) ^ (s[0] ? 16'hB400 : 16'h0000);
    endfunction

    // One step per bit with the MSB taken first
    function automatic int unsigned take_bits(input int n);
        int unsigned v;
        v = 0;
        for (int b = 0; b < n; b++) begin
            v = (v << 1) | int'(lfsr[0]);
            lfsr = lfsr_step(lfsr);
        end
        return v;
    endfunction

    // All packets handed in and every sent beat seen on egress
    function automatic logic drained();
        int tx_sum;
        int rx_sum;
        tx_sum = 0;
        rx_sum = 0;
        for (int s = 0; s < num_ports; s++) begin
            if (pkts_left[s] != 0) return 1'b0;
            for (int d = 0; d < num_ports; d++) begin
                tx_sum += int'(tx_cnt[s][d]);
                rx_sum += int'(rx_cnt[s][d]);
            end
        end
        return tx_sum == rx_sum;
    endfunction

    // ==============================
    // Stimulus on the falling edge
    // ==============================

    always @(negedge clk) begin
        if (rst_n) begin
            for (int s = 0; s < num_ports; s++) begin
                // Beat taken at the last rising edge
                if (will_xfer[s]) begin
                    sent_last[s][cur_dest[s]][tx_cnt[s][cur_dest[s]][7:0]] =
                        igr_beat[s].tlast;
                    tx_cnt[s][cur_dest[s]] = tx_cnt[s][cur_dest[s]] + 16'd1;
                    beats_left[s] = beats_left[s] - 1;
                    igr_tvalid[s] = 1'b0;
                    if (beats_left[s] == 0) begin
                        pkts_left[s] = pkts_left[s] - 1;
                        gap_left[s]  = int'(take_bits(2));
                    end
                end
                if (!igr_tvalid[s] && pkts_left[s] > 0) begin
                    if (gap_left[s] > 0) begin
                        gap_left[s] = gap_left[s] - 1;
                    end else begin
                        // New packet header
                        if (beats_left[s] == 0) begin
                            beats_left[s] = int'(take_bits(3)) + 1;
                            cur_dest[s]   = port_t'(take_bits(2));
                        end
                        igr_beat[s].tdata = {port_t'(s), cur_dest[s], 44'd0,
                                             tx_cnt[s][cur_dest[s]]};
                        igr_beat[s].tlast = (beats_left[s] == 1);
                        igr_beat[s].tdest = cur_dest[s];
                        igr_tvalid[s]     = 1'b1;
                    end
                end
                // Ready only moves on the rising edge
                will_xfer[s] = igr_tvalid[s] && igr_tready[s];
            end
            // Ready low about a quarter of the time
            for (int j = 0; j < num_ports; j++) begin
                egr_tready[j] = (take_bits(2) != 0);
            end
        end
    end

    // ==============================
    // Egress scoreboard
    // ==============================

    always_comb begin
        for (int j = 0; j < num_ports; j++) egr_xfer[j] = egr_tvalid[j] && egr_tready[j];
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            for (int j = 0; j < num_ports; j++) begin
                pkt_open[j] <= 1'b0;
                stall_q[j]  <= 1'b0;
                for (int s = 0; s < num_ports; s++) rx_cnt[s][j] <= '0;
            end
        end else begin
            for (int j = 0; j < num_ports; j++) begin
                stall_q[j]   <= egr_tvalid[j] && !egr_tready[j];
                held_beat[j] <= egr_beat[j];
                if (egr_xfer[j]) begin
                    rx_cnt[egr_beat[j].tdata[63:62]][j] <=
                        rx_cnt[egr_beat[j].tdata[63:62]][j] + 16'd1;
                    pkt_open[j] <= !egr_beat[j].tlast;
                    pkt_tid[j]  <= egr_beat[j].tid;
                end
            end
        end
    end

    for (genvar j = 0; j < num_ports; j++) begin : g_chk
        routing: assert property (@(posedge clk) disable iff (!rst_n)
            egr_xfer[j] |-> egr_beat[j].tdata[61:60] == port_t'(j))
            else begin
                errors = errors + 1;
                $display("MISMATCH routing port %0d expected %0d actual %0d",
                         j, j, $sampled(egr_beat[j].tdata[61:60]));
            end

        source_tag: assert property (@(posedge clk) disable iff (!rst_n)
            egr_xfer[j] |-> egr_beat[j].tid == egr_beat[j].tdata[63:62])
            else begin
                errors = errors + 1;
                $display("MISMATCH source_tag port %0d expected %0d actual %0d", j,
                         $sampled(egr_beat[j].tdata[63:62]), $sampled(egr_beat[j].tid));
            end

        // Open packet keeps its source until tlast
        atomicity: assert property (@(posedge clk) disable iff (!rst_n)
            (egr_xfer[j] && pkt_open[j]) |-> egr_beat[j].tid == pkt_tid[j])
            else begin
                errors = errors + 1;
                $display("MISMATCH atomicity port %0d expected %0d actual %0d", j,
                         $sampled(pkt_tid[j]), $sampled(egr_beat[j].tid));
            end

        // Packet boundary on egress matches the one sent with that beat
        framing: assert property (@(posedge clk) disable iff (!rst_n)
            egr_xfer[j] |-> egr_beat[j].tlast ==
                sent_last[egr_beat[j].tdata[63:62]][j][egr_beat[j].tdata[7:0]])
            else begin
                errors = errors + 1;
                $display("MISMATCH framing port %0d expected %0d actual %0d", j,
                         $sampled(sent_last[egr_beat[j].tdata[63:62]][j]
                                           [egr_beat[j].tdata[7:0]]),
                         $sampled(egr_beat[j].tlast));
            end

        ordering: assert property (@(posedge clk) disable iff (!rst_n)
            egr_xfer[j] |-> egr_beat[j].tdata[15:0] == rx_cnt[egr_beat[j].tdata[63:62]][j])
            else begin
                errors = errors + 1;
                $display("MISMATCH ordering port %0d expected %0d actual %0d", j,
                         $sampled(rx_cnt[egr_beat[j].tdata[63:62]][j]),
                         $sampled(egr_beat[j].tdata[15:0]));
            end

        // Stalled beat must still be there one edge later
        backpressure: assert property (@(posedge clk) disable iff (!rst_n)
            stall_q[j] |-> (egr_tvalid[j] && egr_beat[j] == held_beat[j]))
            else begin
                errors = errors + 1;
                $display("MISMATCH backpressure port %0d expected %h actual %h", j,
                         $sampled(held_beat[j]), $sampled(egr_beat[j]));
            end

        // Expected {valid, ready} is 2'b01 right after reset
        reset_state: assert property (@(posedge clk)
            $rose(rst_n) |-> (!egr_tvalid[j] && igr_tready[j]))
            else begin
                errors = errors + 1;
                $display("MISMATCH reset_state port %0d expected %b actual %b", j, 2'b01,
                         {$sampled(egr_tvalid[j]), $sampled(igr_tready[j])});
            end
    end

    // ==============================
    // Run control
    // ==============================

    initial begin
        #(run_limit_ns);
        errors = errors + 1;
        $display("Timeout after %0d ns with egress still not drained", run_limit_ns);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        lfsr   = 16'd47054;
        errors = 0;
        rst_n  = 1'b0;
        for (int s = 0; s < num_ports; s++) begin
            igr_tvalid[s] = 1'b0;
            igr_beat[s]   = '0;
            egr_tready[s] = 1'b0;
            pkts_left[s]  = pkts_per_port;
            beats_left[s] = 0;
            gap_left[s]   = 0;
            cur_dest[s]   = '0;
            will_xfer[s]  = 1'b0;
            for (int d = 0; d < num_ports; d++) tx_cnt[s][d] = '0;
        end
        repeat (2) @(negedge clk);
        rst_n <= 1'b1;
        do @(posedge clk); while (!drained());
        repeat (4) @(negedge clk);
        // Every pair fully delivered
        for (int s = 0; s < num_ports; s++) begin
            for (int d = 0; d < num_ports; d++) begin
                assert (rx_cnt[s][d] == tx_cnt[s][d])
                else begin
                    errors = errors + 1;
                    $display("MISMATCH completeness src %0d dst %0d expected %0d actual %0d",
                             s, d, tx_cnt[s][d], rx_cnt[s][d]);
                end
            end
        end
        $display("Run finished with %0d errors", errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule : tb
